// ==== sources.f ====
hdl/soc_cfg_pkg.sv
hdl/bus_pkg.sv
hdl/boot_rom.sv
hdl/main_sram.sv
hdl/clint_timer.sv
hdl/debug_holdoff.sv
hdl/bus_fabric.sv
hdl/harness_top.sv
bench/bus_assertions.sv
bench/harness_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module harness_tb \
  -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vharness_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^TESTS PASSED$'; then
  exit 0
fi
exit 1

// ==== bench/harness_tb.sv ====
// Table-driven testbench for the harness top level
// Clock and reset, hold-off check, bus access table, CLINT side checks

`timescale 1ns/1ps
`default_nettype none

module harness_tb
  import soc_cfg_pkg::*;
  import bus_pkg::*;
();

  localparam int ClkPeriod   = 40;
  localparam int RspTimeout  = 5;
  localparam int IrqTimeout  = 20;
  localparam int HoldOff     = 16;
  localparam int SramDepth   = 256;

  typedef enum logic [1:0] {
    PortHost,
    PortDbg,
    PortBoth
  } port_e;

  // Extra checks run after a row's response
  typedef enum logic [2:0] {
    SideNone,
    SideIpiHigh,
    SideIpiLow,
    SideIrqRise,
    SideIrqLow
  } side_e;

  typedef struct packed {
    port_e       port;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        chk_data;
    side_e       side;
  } vec_t;

  logic     clk_i;
  logic     rst_ni;
  logic     rtc_i;
  logic     host_req_valid_i;
  bus_req_t host_req_i;
  logic     host_rsp_valid_o;
  bus_rsp_t host_rsp_o;
  logic     dbg_req_valid_i;
  bus_req_t dbg_req_i;
  logic     dbg_rsp_valid_o;
  bus_rsp_t dbg_rsp_o;
  logic     debug_halt_i;
  logic     debug_req_o;
  logic     timer_irq_o;
  logic     ipi_o;

  vec_t   vecs[$];
  string  vec_name[$];
  integer seed;
  int     pass_cnt;
  int     fail_cnt;
  int     row;

  harness_top u_harness_top (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .rtc_i            ( rtc_i            ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_req_i       ( host_req_i       ),
    .host_rsp_valid_o ( host_rsp_valid_o ),
    .host_rsp_o       ( host_rsp_o       ),
    .dbg_req_valid_i  ( dbg_req_valid_i  ),
    .dbg_req_i        ( dbg_req_i        ),
    .dbg_rsp_valid_o  ( dbg_rsp_valid_o  ),
    .dbg_rsp_o        ( dbg_rsp_o        ),
    .debug_halt_i     ( debug_halt_i     ),
    .debug_req_o      ( debug_req_o      ),
    .timer_irq_o      ( timer_irq_o      ),
    .ipi_o            ( ipi_o            )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Reference model helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] rom_word(int idx);
    return {RomTag, 16'(idx % RomWords)};
  endfunction

  function automatic logic [31:0] word_addr(logic [3:0] region, int idx);
    return {region, 28'(idx * 4)};
  endfunction

  function automatic void add_vec(string name, port_e port, logic we, logic [31:0] addr,
                                  logic [3:0] be, logic [31:0] wdata, logic [31:0] exp_rdata,
                                  logic exp_err, logic chk_data, side_e side);
    vec_t v;
    v.port      = port;
    v.we        = we;
    v.addr      = addr;
    v.be        = be;
    v.wdata     = wdata;
    v.exp_rdata = exp_rdata;
    v.exp_err   = exp_err;
    v.chk_data  = chk_data;
    v.side      = side;
    vecs.push_back(v);
    vec_name.push_back(name);
  endfunction

  // A PortBoth row is the debug side, the row after it the host side
  function automatic void build_table();
    logic [31:0] d0, d1, d2, d3, d4, d5;
    logic [31:0] m5;
    logic [31:0] m20;
    d0  = $random(seed);
    d1  = $random(seed);
    d2  = $random(seed);
    d3  = $random(seed);
    d4  = $random(seed);
    d5  = $random(seed);
    m5  = merge_bytes(d0, d1, 4'b0101);
    m20 = merge_bytes(d2, d3, 4'b1000);
    // Boot ROM
    add_vec("rom_rd_0", PortHost, 0, word_addr(RegionRom, 0), 4'hF, 0, rom_word(0), 0, 1, SideNone);
    add_vec("rom_rd_3", PortHost, 0, word_addr(RegionRom, 3), 4'hF, 0, rom_word(3), 0, 1, SideNone);
    add_vec("rom_rd_15", PortHost, 0, word_addr(RegionRom, 15), 4'hF, 0, rom_word(15), 0, 1,
            SideNone);
    add_vec("rom_rd_wrap", PortHost, 0, word_addr(RegionRom, 21), 4'hF, 0, rom_word(21), 0, 1,
            SideNone);
    add_vec("rom_wr_err", PortHost, 1, word_addr(RegionRom, 2), 4'hF, d5, 0, 1, 1, SideNone);
    // SRAM
    add_vec("sram_wr_full", PortHost, 1, word_addr(RegionSram, 5), 4'hF, d0, d0, 0, 1, SideNone);
    add_vec("sram_wr_part", PortHost, 1, word_addr(RegionSram, 5), 4'b0101, d1, m5, 0, 1,
            SideNone);
    add_vec("sram_rd_dbg", PortDbg, 0, word_addr(RegionSram, 5), 4'hF, 0, m5, 0, 1, SideNone);
    add_vec("sram_wr_dbg", PortDbg, 1, word_addr(RegionSram, 32), 4'hF, d2, d2, 0, 1, SideNone);
    add_vec("sram_wr_wrap", PortDbg, 1, word_addr(RegionSram, 32 + SramDepth), 4'b1000, d3, m20,
            0, 1, SideNone);
    add_vec("sram_rd_host", PortHost, 0, word_addr(RegionSram, 32), 4'hF, 0, m20, 0, 1, SideNone);
    // Unmapped regions
    add_vec("unmap_host", PortHost, 0, 32'h4000_0000, 4'hF, 0, 0, 1, 1, SideNone);
    add_vec("unmap_dbg", PortDbg, 1, 32'hF000_0010, 4'hF, d5, 0, 1, 1, SideNone);
    // Same-cycle strobes from both masters
    add_vec("pair_rom_dbg", PortBoth, 0, word_addr(RegionRom, 7), 4'hF, 0, rom_word(7), 0, 1,
            SideNone);
    add_vec("pair_sram_host", PortHost, 0, word_addr(RegionSram, 5), 4'hF, 0, m5, 0, 1, SideNone);
    add_vec("pair_wr_dbg", PortBoth, 1, word_addr(RegionSram, 40), 4'hF, d4, d4, 0, 1, SideNone);
    add_vec("pair_rd_host", PortHost, 0, word_addr(RegionSram, 40), 4'hF, 0, d4, 0, 1, SideNone);
    add_vec("pair_unmap_dbg", PortBoth, 0, 32'h4000_0000, 4'hF, 0, 0, 1, 1, SideNone);
    add_vec("pair_rom_host", PortHost, 0, word_addr(RegionRom, 2), 4'hF, 0, rom_word(2), 0, 1,
            SideNone);
    // CLINT, write data of register writes is not compared
    add_vec("msip_set", PortHost, 1, 32'h2000_0000, 4'hF, 1, 0, 0, 0, SideIpiHigh);
    add_vec("msip_rd", PortDbg, 0, 32'h2000_0000, 4'hF, 0, 1, 0, 1, SideNone);
    add_vec("msip_clr", PortHost, 1, 32'h2000_0000, 4'hF, 0, 0, 0, 0, SideIpiLow);
    add_vec("mtime_clr", PortHost, 1, 32'h2000_0008, 4'hF, 0, 0, 0, 0, SideNone);
    add_vec("cmp_set", PortHost, 1, 32'h2000_0004, 4'hF, 10, 0, 0, 0, SideIrqRise);
    add_vec("cmp_rd", PortDbg, 0, 32'h2000_0004, 4'hF, 0, 10, 0, 1, SideNone);
    add_vec("cmp_max", PortHost, 1, 32'h2000_0004, 4'hF, 32'hFFFF_FFFF, 0, 0, 0, SideIrqLow);
    add_vec("clint_bad_off", PortHost, 0, 32'h2000_000C, 4'hF, 0, 0, 1, 1, SideNone);
  endfunction

  function automatic bus_req_t to_req(vec_t v);
    bus_req_t r;
    r.we       = v.we;
    r.addr.raw = v.addr;
    r.be       = v.be;
    r.wdata    = v.wdata;
    return r;
  endfunction

  // ----------------------------------------------------------
  // Checking and reporting
  // ----------------------------------------------------------
  task automatic record_result(input string name, input logic bad);
    if (bad) begin
      fail_cnt++;
    end else begin
      pass_cnt++;
      $display("ok    %s", name);
    end
  endtask

  task automatic check_side(input vec_t v, input string name, output logic bad);
    int   n;
    logic exp_bit;
    bad     = 1'b0;
    exp_bit = (v.side == SideIpiHigh);
    n       = 0;
    case (v.side)
      SideIpiHigh, SideIpiLow: begin
        if (ipi_o !== exp_bit) begin
          $display("Error %s: expected ipi_o %b, actual %b", name, exp_bit, ipi_o);
          bad = 1'b1;
        end
      end
      SideIrqLow: begin
        if (timer_irq_o !== 1'b0) begin
          $display("Error %s: expected timer_irq_o 0, actual %b", name, timer_irq_o);
          bad = 1'b1;
        end
      end
      SideIrqRise: begin
        while (timer_irq_o !== 1'b1 && n < IrqTimeout) begin
          @(negedge clk_i);
          n++;
        end
        if (timer_irq_o !== 1'b1) begin
          $display("%s: timer interrupt did not rise within %0d cycles", name, IrqTimeout);
          bad = 1'b1;
        end
      end
      default: begin
        bad = 1'b0;
      end
    endcase
  endtask

  task automatic check_row(input int idx, input logic got, input bus_rsp_t rsp,
                           input int lat, input int exp_lat);
    vec_t  v;
    string name;
    logic  bad;
    v    = vecs[idx];
    name = vec_name[idx];
    bad  = 1'b0;
    if (!got) begin
      $display("%s: no response strobe within %0d cycles", name, RspTimeout);
      bad = 1'b1;
    end else if (rsp.err !== v.exp_err || (v.chk_data && rsp.rdata !== v.exp_rdata)) begin
      $display("Error %s: expected rdata %h err %b, actual rdata %h err %b",
               name, v.exp_rdata, v.exp_err, rsp.rdata, rsp.err);
      bad = 1'b1;
    end else if (lat != exp_lat) begin
      // A held host request answers one cycle after the debug one
      $display("Error %s: expected latency %0d, actual latency %0d", name, exp_lat, lat);
      bad = 1'b1;
    end else begin
      check_side(v, name, bad);
    end
    record_result(name, bad);
  endtask

  // Issue one row per port, index -1 leaves that port idle
  task automatic run_access(input int hi, input int di);
    logic     h_got;
    logic     d_got;
    bus_rsp_t h_rsp;
    bus_rsp_t d_rsp;
    int       h_lat;
    int       d_lat;
    int       cyc;
    h_got = (hi < 0);
    d_got = (di < 0);
    h_rsp = '0;
    d_rsp = '0;
    h_lat = 0;
    d_lat = 0;
    cyc   = 0;
    if (hi >= 0) begin
      host_req_i       = to_req(vecs[hi]);
      host_req_valid_i = 1'b1;
    end
    if (di >= 0) begin
      dbg_req_i       = to_req(vecs[di]);
      dbg_req_valid_i = 1'b1;
    end
    while (!(h_got && d_got) && cyc < RspTimeout) begin
      @(negedge clk_i);
      cyc++;
      if (!h_got && host_rsp_valid_o) begin
        h_got = 1'b1;
        h_lat = cyc;
        h_rsp = host_rsp_o;
      end
      if (!d_got && dbg_rsp_valid_o) begin
        d_got = 1'b1;
        d_lat = cyc;
        d_rsp = dbg_rsp_o;
      end
      host_req_valid_i = 1'b0;
      dbg_req_valid_i  = 1'b0;
    end
    if (di >= 0) begin
      check_row(di, d_got, d_rsp, d_lat, 1);
    end
    if (hi >= 0) begin
      check_row(hi, h_got, h_rsp, h_lat, (di >= 0) ? 2 : 1);
    end
  endtask

  // Halt held high since reset release, edges counted after release
  task automatic check_holdoff();
    logic bad;
    bad = 1'b0;
    for (int k = 1; k <= HoldOff + 1; k++) begin
      @(negedge clk_i);
      if (!bad && k < HoldOff && debug_req_o !== 1'b0) begin
        $display("Error debug_holdoff: expected debug_req_o 0 after edge %0d, actual %b",
                 k, debug_req_o);
        bad = 1'b1;
      end
      if (!bad && k == HoldOff + 1 && debug_req_o !== 1'b1) begin
        $display("Error debug_holdoff: expected debug_req_o 1 after edge %0d, actual %b",
                 k, debug_req_o);
        bad = 1'b1;
      end
    end
    record_result("debug_holdoff", bad);
    debug_halt_i = 1'b0;
    @(negedge clk_i);
    bad = 1'b0;
    if (debug_req_o !== 1'b0) begin
      $display("Error debug_release: expected debug_req_o 0, actual %b", debug_req_o);
      bad = 1'b1;
    end
    record_result("debug_release", bad);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_ni           = 1'b0;
    rtc_i            = 1'b0;
    host_req_valid_i = 1'b0;
    host_req_i       = '0;
    dbg_req_valid_i  = 1'b0;
    dbg_req_i        = '0;
    debug_halt_i     = 1'b1;
    seed             = 77503;
    pass_cnt         = 0;
    fail_cnt         = 0;
    build_table();
    // Two rising edges in reset, release on the falling edge
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_holdoff();
    rtc_i = 1'b1;
    row   = 0;
    while (row < vecs.size()) begin
      if (vecs[row].port == PortBoth) begin
        run_access(row + 1, row);
        row += 2;
      end else if (vecs[row].port == PortHost) begin
        run_access(row, -1);
        row++;
      end else begin
        run_access(-1, row);
        row++;
      end
    end
    $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/bus_assertions.sv ====
// Bound checks on response timing, reset quiet cycle and debug gating

`timescale 1ns/1ps
`default_nettype none

module bus_assertions #(
  parameter int unsigned HoldOffCycles = 16
) (
  input logic clk_i,
  input logic rst_ni,
  input logic host_req_valid_i,
  input logic host_rsp_valid_o,
  input logic dbg_req_valid_i,
  input logic dbg_rsp_valid_o,
  input logic debug_halt_i,
  input logic debug_req_o
);

  // ----------------------------------------------------------
  // Response timing
  // ----------------------------------------------------------
  host_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp_valid_o |-> ($past(host_req_valid_i) || $past(host_req_valid_i, 2)))
    else $error("host response strobe without a host request one or two cycles earlier");

  dbg_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rsp_valid_o |-> ($past(dbg_req_valid_i) || $past(dbg_req_valid_i, 2)))
    else $error("debug response strobe without a debug request one or two cycles earlier");

  // First cycle out of reset is quiet
  no_rsp_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |=> (!host_rsp_valid_o && !dbg_rsp_valid_o))
    else $error("response strobe in the first cycle after reset");

  // Halt request passes only after the hold-off window
  debug_req_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o |-> (debug_halt_i && $past(rst_ni, HoldOffCycles)))
    else $error("debug_req_o high while debug_halt_i is low or inside the hold-off window");

endmodule

bind harness_top bus_assertions #(
  .HoldOffCycles ( HoldOffCycles )
) u_bus_assertions (
  .clk_i            ( clk_i            ),
  .rst_ni           ( rst_ni           ),
  .host_req_valid_i ( host_req_valid_i ),
  .host_rsp_valid_o ( host_rsp_valid_o ),
  .dbg_req_valid_i  ( dbg_req_valid_i  ),
  .dbg_rsp_valid_o  ( dbg_rsp_valid_o  ),
  .debug_halt_i     ( debug_halt_i     ),
  .debug_req_o      ( debug_req_o      )
);

`default_nettype wire

// ==== hdl/harness_top.sv ====
// Harness top level with host and debug bus ports
// Connects the fabric, boot ROM, SRAM, CLINT and debug hold-off

`timescale 1ns/1ps
`default_nettype none

module harness_top
  import bus_pkg::*;
#(
  parameter int unsigned SramWords     = 256,
  parameter int unsigned HoldOffCycles = 16
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     host_req_valid_i,
  input  bus_req_t host_req_i,
  output logic     host_rsp_valid_o,
  output bus_rsp_t host_rsp_o,
  input  logic     dbg_req_valid_i,
  input  bus_req_t dbg_req_i,
  output logic     dbg_rsp_valid_o,
  output bus_rsp_t dbg_rsp_o,
  input  logic     debug_halt_i,
  output logic     debug_req_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  bus_req_t slv_req;
  logic     rom_sel;
  logic     clint_sel;
  logic     sram_sel;
  bus_rsp_t rom_rsp;
  bus_rsp_t clint_rsp;
  bus_rsp_t sram_rsp;

  // ----------------------------------------------------------
  // Interconnect
  // ----------------------------------------------------------
  bus_fabric u_bus_fabric (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_req_i       ( host_req_i       ),
    .host_rsp_valid_o ( host_rsp_valid_o ),
    .host_rsp_o       ( host_rsp_o       ),
    .dbg_req_valid_i  ( dbg_req_valid_i  ),
    .dbg_req_i        ( dbg_req_i        ),
    .dbg_rsp_valid_o  ( dbg_rsp_valid_o  ),
    .dbg_rsp_o        ( dbg_rsp_o        ),
    .slv_req_o        ( slv_req          ),
    .rom_sel_o        ( rom_sel          ),
    .clint_sel_o      ( clint_sel        ),
    .sram_sel_o       ( sram_sel         ),
    .rom_rsp_i        ( rom_rsp          ),
    .clint_rsp_i      ( clint_rsp        ),
    .sram_rsp_i       ( sram_rsp         )
  );

  // ----------------------------------------------------------
  // Targets
  // ----------------------------------------------------------
  boot_rom u_boot_rom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .sel_i  ( rom_sel ),
    .req_i  ( slv_req ),
    .rsp_o  ( rom_rsp )
  );

  main_sram #(
    .SramWords ( SramWords )
  ) u_main_sram (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .sel_i  ( sram_sel ),
    .req_i  ( slv_req  ),
    .rsp_o  ( sram_rsp )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .sel_i       ( clint_sel   ),
    .req_i       ( slv_req     ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Debug gating
  debug_holdoff #(
    .HoldOffCycles ( HoldOffCycles )
  ) u_debug_holdoff (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .debug_halt_i ( debug_halt_i ),
    .debug_req_o  ( debug_req_o  )
  );

endmodule

`default_nettype wire

// ==== hdl/bus_fabric.sv ====
// Two-master bus fabric with fixed debug priority
// Host hold register, region decoder, error responder, response router

`timescale 1ns/1ps
`default_nettype none

module bus_fabric
  import soc_cfg_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     host_req_valid_i,
  input  bus_req_t host_req_i,
  output logic     host_rsp_valid_o,
  output bus_rsp_t host_rsp_o,
  input  logic     dbg_req_valid_i,
  input  bus_req_t dbg_req_i,
  output logic     dbg_rsp_valid_o,
  output bus_rsp_t dbg_rsp_o,
  output bus_req_t slv_req_o,
  output logic     rom_sel_o,
  output logic     clint_sel_o,
  output logic     sram_sel_o,
  input  bus_rsp_t rom_rsp_i,
  input  bus_rsp_t clint_rsp_i,
  input  bus_rsp_t sram_rsp_i
);

  logic     hold_valid_q;
  logic     hold_valid_d;
  bus_req_t hold_req_q;
  logic     issue_valid;
  logic     issue_dbg;
  bus_req_t issue_req;
  target_e  issue_tgt;
  logic     rsp_valid_q;
  logic     rsp_dbg_q;
  target_e  rsp_tgt_q;
  bus_rsp_t routed_rsp;

  function automatic target_e decode_region(logic [RegionWidth-1:0] region);
    case (region)
      RegionRom:   return TargetRom;
      RegionClint: return TargetClint;
      RegionSram:  return TargetSram;
      default:     return TargetNone;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------
  // Debug first, then a held host request, then a fresh host strobe
  always_comb begin
    issue_valid = 1'b1;
    issue_dbg   = 1'b0;
    issue_req   = host_req_i;
    if (dbg_req_valid_i) begin
      issue_dbg = 1'b1;
      issue_req = dbg_req_i;
    end else if (hold_valid_q) begin
      issue_req = hold_req_q;
    end else begin
      issue_valid = host_req_valid_i;
    end
  end

  // Losing host request is captured, or kept if debug wins again
  assign hold_valid_d = dbg_req_valid_i & (host_req_valid_i | hold_valid_q);

  always_ff @(posedge clk_i) begin
    if (dbg_req_valid_i && host_req_valid_i) begin
      hold_req_q <= host_req_i;
    end
  end

  // ----------------------------------------------------------
  // Decode and target select
  // ----------------------------------------------------------
  assign issue_tgt   = decode_region(issue_req.addr.f.region);
  assign slv_req_o   = issue_req;
  assign rom_sel_o   = issue_valid && (issue_tgt == TargetRom);
  assign clint_sel_o = issue_valid && (issue_tgt == TargetClint);
  assign sram_sel_o  = issue_valid && (issue_tgt == TargetSram);

  // Owner and target tag of the request in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
      rsp_dbg_q    <= 1'b0;
      rsp_tgt_q    <= TargetNone;
    end else begin
      hold_valid_q <= hold_valid_d;
      rsp_valid_q  <= issue_valid;
      rsp_dbg_q    <= issue_dbg;
      rsp_tgt_q    <= issue_tgt;
    end
  end

  // ----------------------------------------------------------
  // Response routing
  // ----------------------------------------------------------
  always_comb begin
    case (rsp_tgt_q)
      TargetRom:   routed_rsp = rom_rsp_i;
      TargetClint: routed_rsp = clint_rsp_i;
      TargetSram:  routed_rsp = sram_rsp_i;
      default: begin
        // Unmapped region
        routed_rsp.rdata = '0;
        routed_rsp.err   = 1'b1;
      end
    endcase
  end

  assign host_rsp_valid_o = rsp_valid_q & ~rsp_dbg_q;
  assign dbg_rsp_valid_o  = rsp_valid_q & rsp_dbg_q;
  assign host_rsp_o       = routed_rsp;
  assign dbg_rsp_o        = routed_rsp;

endmodule

`default_nettype wire

// ==== hdl/debug_holdoff.sv ====
// Post-reset hold-off that keeps the debug halt request away from the core

`timescale 1ns/1ps
`default_nettype none

module debug_holdoff #(
  parameter int unsigned HoldOffCycles = 16
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_halt_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(HoldOffCycles + 1);

  logic [CntWidth-1:0] cnt_q;

  // Count down once per edge until zero, then stay there
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(HoldOffCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Halt passes through once the window has expired
  assign debug_req_o = (cnt_q == '0) && debug_halt_i;

endmodule

`default_nettype wire

// ==== hdl/clint_timer.sv ====
// Core-local interruptor with msip, mtimecmp and mtime registers
// Software and timer interrupt outputs come straight from the registers

`timescale 1ns/1ps
`default_nettype none

module clint_timer
  import soc_cfg_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     sel_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic                 msip_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] msip_word;
  logic [DataWidth-1:0] msip_new;
  logic                 hit_msip;
  logic                 hit_cmp;
  logic                 hit_time;
  logic                 wr;
  bus_rsp_t             rd_rsp;
  bus_rsp_t             rsp_q;

  // ----------------------------------------------------------
  // Register decode
  // ----------------------------------------------------------
  assign hit_msip = req_i.addr.f.word_idx == WordIdxWidth'(ClintMsipOff / ByteLanes);
  assign hit_cmp  = req_i.addr.f.word_idx == WordIdxWidth'(ClintCmpOff / ByteLanes);
  assign hit_time = req_i.addr.f.word_idx == WordIdxWidth'(ClintTimeOff / ByteLanes);
  assign wr       = sel_i & req_i.we;

  assign msip_word = {{(DataWidth-1){1'b0}}, msip_q};
  assign msip_new  = apply_be(msip_word, req_i.wdata, req_i.be);

  // Read data reflects the value before any write in the same access
  always_comb begin
    rd_rsp.rdata = '0;
    rd_rsp.err   = 1'b0;
    if (hit_msip) begin
      rd_rsp.rdata = msip_word;
    end else if (hit_cmp) begin
      rd_rsp.rdata = mtimecmp_q;
    end else if (hit_time) begin
      rd_rsp.rdata = mtime_q;
    end else begin
      rd_rsp.err = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      rsp_q      <= '0;
    end else begin
      if (wr && hit_msip) begin
        msip_q <= msip_new[0];
      end
      if (wr && hit_cmp) begin
        mtimecmp_q <= apply_be(mtimecmp_q, req_i.wdata, req_i.be);
      end
      // Bus write wins over the rtc tick
      if (wr && hit_time) begin
        mtime_q <= apply_be(mtime_q, req_i.wdata, req_i.be);
      end else if (rtc_i) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (sel_i) begin
        rsp_q <= rd_rsp;
      end
    end
  end

  assign rsp_o       = rsp_q;
  assign ipi_o       = msip_q;
  assign timer_irq_o = mtime_q >= mtimecmp_q;

endmodule

`default_nettype wire

// ==== hdl/main_sram.sv ====
// Word SRAM target with per-byte write enables
// Write responds with the merged word, read with the stored word

`timescale 1ns/1ps
`default_nettype none

module main_sram
  import soc_cfg_pkg::*;
  import bus_pkg::*;
#(
  parameter int unsigned SramWords = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     sel_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(SramWords);

  logic [DataWidth-1:0] mem_q [SramWords];
  logic [IdxWidth-1:0]  idx;
  logic [DataWidth-1:0] merged;
  bus_rsp_t             rsp_q;

  // Addresses wrap modulo SramWords
  assign idx    = req_i.addr.f.word_idx[IdxWidth-1:0];
  assign merged = apply_be(mem_q[idx], req_i.wdata, req_i.be);

  // Storage array
  always_ff @(posedge clk_i) begin
    if (sel_i && req_i.we) begin
      mem_q[idx] <= merged;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else if (sel_i) begin
      rsp_q.rdata <= req_i.we ? merged : mem_q[idx];
      rsp_q.err   <= 1'b0;
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== hdl/boot_rom.sv ====
// Boot ROM target returning a fixed tagged index pattern

`timescale 1ns/1ps
`default_nettype none

module boot_rom
  import soc_cfg_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     sel_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(RomWords);
  localparam int unsigned LowWidth = DataWidth - 16;

  logic [IdxWidth-1:0] rom_idx;
  bus_rsp_t            rsp_q;

  // Index wraps on the low word index bits
  assign rom_idx = req_i.addr.f.word_idx[IdxWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else if (sel_i) begin
      if (req_i.we) begin
        rsp_q.rdata <= '0;
        rsp_q.err   <= 1'b1;
      end else begin
        rsp_q.rdata <= {RomTag, LowWidth'(rom_idx)};
        rsp_q.err   <= 1'b0;
      end
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
// Shared bus types for masters, fabric and targets
// Address union, request and response structs, target select enum
// Byte-enable merge helper used by the writable targets

`default_nettype none

package bus_pkg;
  import soc_cfg_pkg::*;

  localparam int unsigned RegionWidth  = 4;
  localparam int unsigned ByteOffWidth = 2;
  localparam int unsigned WordIdxWidth = AddrWidth - RegionWidth - ByteOffWidth;

  // Address split as the fabric and targets see it
  typedef struct packed {
    logic [RegionWidth-1:0]  region;
    logic [WordIdxWidth-1:0] word_idx;
    logic [ByteOffWidth-1:0] byte_off;
  } bus_addr_fields_t;

  typedef union packed {
    logic [AddrWidth-1:0] raw;
    bus_addr_fields_t     f;
  } bus_addr_u;

  typedef struct packed {
    logic                 we;
    bus_addr_u            addr;
    logic [ByteLanes-1:0] be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TargetRom,
    TargetClint,
    TargetSram,
    TargetNone
  } target_e;

  // Replace the enabled byte lanes of old_data with new_data
  function automatic logic [DataWidth-1:0] apply_be(
    logic [DataWidth-1:0] old_data,
    logic [DataWidth-1:0] new_data,
    logic [ByteLanes-1:0] be
  );
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int b = 0; b < ByteLanes; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/soc_cfg_pkg.sv ====
// SoC configuration constants for the test harness
// Address map region codes, bus widths, ROM pattern and CLINT offsets

`default_nettype none

package soc_cfg_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  localparam int unsigned DataWidth = 32;
  localparam int unsigned ByteLanes = DataWidth / 8;
  localparam int unsigned AddrWidth = 32;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  // Region code lives in the top four address bits
  localparam logic [3:0] RegionRom   = 4'h0;
  localparam logic [3:0] RegionClint = 4'h2;
  localparam logic [3:0] RegionSram  = 4'h8;

  // Boot ROM pattern
  localparam int unsigned RomWords = 16;
  localparam logic [15:0] RomTag   = 16'hB007;

  // CLINT register byte offsets
  localparam int unsigned ClintMsipOff = 0;
  localparam int unsigned ClintCmpOff  = 4;
  localparam int unsigned ClintTimeOff = 8;

endpackage

`default_nettype wire
